// File: hw/st_pkg.sv
package st_pkg;

	// ram size select, ctrl word bits 3:1
	typedef enum logic [2:0] {
		MEM_512K = 3'd0,
		MEM_1M   = 3'd1,
		MEM_2M   = 3'd2,
		MEM_4M   = 3'd3,
		MEM_8M   = 3'd4,
		MEM_14M  = 3'd5 // 6 and 7 select no ram at all
	} mem_size_e;

	// 68000 word address, a23..a1
	typedef logic [23:1] bus_addr_t;

	// axi4-lite byte offsets
	localparam logic [7:0] CTRL_OFFSET   = 8'h00; // control word, r/w
	localparam logic [7:0] STATUS_OFFSET = 8'h04; // viking status, ro

	// control word layout
	localparam int CTRL_MEM_LSB    = 1;  // 3 bit size field
	localparam int CTRL_STE_BIT    = 23;
	localparam int CTRL_MSTE_BIT   = 24;
	localparam int CTRL_VIKING_BIT = 28;

	// viking video ram windows
	// plain mode sits at $c00000..$c3ffff, compared on a23..a18
	localparam logic [5:0] VIKING_BASE_ST = 6'b110000;
	// steroids mode moves it to $e80000..$efffff, a23..a19
	localparam logic [4:0] VIKING_BASE_HI = 5'b11101;

	// audio widths
	localparam int YM_W  = 10; // psg mix per side
	localparam int DMA_W = 8;  // ste dma sound
	localparam int MIX_W = 15; // summed, feeds the dac

endpackage

// File: hw/st_cfg_if.sv
interface st_cfg_if;

	st_pkg::mem_size_e mem_size;      // selected ram size
	logic              steroids;      // ste + mste both set
	logic              viking_enable; // viking window mapped
	logic [7:0]        viking_hits;   // saturating access count
	logic              viking_active; // driver seen, video switched

	// config owner, reads back detector status
	modport regs (
		output mem_size, steroids, viking_enable,
		input  viking_hits, viking_active
	);

	modport decode (
		input mem_size, steroids, viking_enable
	);

	modport detect (
		input  steroids, viking_enable,
		output viking_hits, viking_active
	);

endinterface

// File: hw/st_cfg_regs.sv
module st_cfg_regs (
	input  logic        clk_32,
	input  logic        xsint,
	// write address
	input  logic [7:0]  s_axil_awaddr_i,
	input  logic        s_axil_awvalid_i,
	output logic        s_axil_awready_o,
	// write data
	input  logic [31:0] s_axil_wdata_i,
	input  logic [3:0]  s_axil_wstrb_i,   // full word writes only
	input  logic        s_axil_wvalid_i,
	output logic        s_axil_wready_o,
	// write response
	output logic [1:0]  s_axil_bresp_o,
	output logic        s_axil_bvalid_o,
	input  logic        s_axil_bready_i,
	// read address
	input  logic [7:0]  s_axil_araddr_i,
	input  logic        s_axil_arvalid_i,
	output logic        s_axil_arready_o,
	// read data
	output logic [31:0] s_axil_rdata_o,
	output logic [1:0]  s_axil_rresp_o,
	output logic        s_axil_rvalid_o,
	input  logic        s_axil_rready_i,
	st_cfg_if.regs      cfg
);

	localparam logic [1:0] RESP_OKAY   = 2'b00;
	localparam logic [1:0] RESP_SLVERR = 2'b10;

	logic        wr_go;   // write accepted this cycle
	logic        rd_go;   // read accepted this cycle
	logic        wr_hit;  // write targets the ctrl word
	logic [31:0] ctrl_q;
	logic [31:0] ctrl_d;  // ctrl word as of the next edge
	logic [31:0] status;
	logic        ste;
	logic        mste;
	logic        mem_ok;  // 8M or less, viking allowed

	// both halves of a write must be there, and no response outstanding
	assign wr_go = s_axil_awvalid_i & s_axil_wvalid_i & ~s_axil_bvalid_o;
	assign rd_go = s_axil_arvalid_i & ~s_axil_rvalid_o;

	assign s_axil_awready_o = wr_go;
	assign s_axil_wready_o  = wr_go; // pulses together with awready
	assign s_axil_arready_o = rd_go;

	assign wr_hit = (s_axil_awaddr_i == st_pkg::CTRL_OFFSET);
	assign ctrl_d = (wr_go && wr_hit) ? s_axil_wdata_i : ctrl_q;

	assign ste    = ctrl_d[st_pkg::CTRL_STE_BIT];
	assign mste   = ctrl_d[st_pkg::CTRL_MSTE_BIT];
	assign mem_ok = (ctrl_d[st_pkg::CTRL_MEM_LSB +: 3] <= st_pkg::MEM_8M);

	assign status = {23'd0, cfg.viking_active, cfg.viking_hits};

	// control word and the config derived from it
	always_ff @(posedge clk_32 or negedge xsint) begin
		if (!xsint) begin
			ctrl_q            <= '0; // 512K, plain st, no viking
			cfg.mem_size      <= st_pkg::MEM_512K;
			cfg.steroids      <= 1'b0;
			cfg.viking_enable <= 1'b0;
		end else begin
			ctrl_q            <= ctrl_d;
			cfg.mem_size      <= st_pkg::mem_size_e'(ctrl_d[st_pkg::CTRL_MEM_LSB +: 3]);
			cfg.steroids      <= ste & mste;
			// steroids maps viking high, so any size goes
			cfg.viking_enable <= (ste & mste) |
				(ctrl_d[st_pkg::CTRL_VIKING_BIT] & mem_ok);
		end
	end

	// response valids, held until the master takes them
	always_ff @(posedge clk_32 or negedge xsint) begin
		if (!xsint) begin
			s_axil_bvalid_o <= 1'b0;
			s_axil_rvalid_o <= 1'b0;
		end else begin
			if (wr_go)
				s_axil_bvalid_o <= 1'b1;
			else if (s_axil_bready_i)
				s_axil_bvalid_o <= 1'b0;

			if (rd_go)
				s_axil_rvalid_o <= 1'b1;
			else if (s_axil_rready_i)
				s_axil_rvalid_o <= 1'b0;
		end
	end

	// response payload, only loaded on acceptance so it stays stable
	always_ff @(posedge clk_32) begin
		if (wr_go)
			s_axil_bresp_o <= wr_hit ? RESP_OKAY : RESP_SLVERR;
		if (rd_go) begin
			case (s_axil_araddr_i)
				st_pkg::CTRL_OFFSET: begin
					s_axil_rdata_o <= ctrl_q;
					s_axil_rresp_o <= RESP_OKAY;
				end
				st_pkg::STATUS_OFFSET: begin
					s_axil_rdata_o <= status;
					s_axil_rresp_o <= RESP_OKAY;
				end
				default: begin
					s_axil_rdata_o <= '0; // unmapped
					s_axil_rresp_o <= RESP_SLVERR;
				end
			endcase
		end
	end

endmodule

// File: hw/st_ram_decode.sv
module st_ram_decode (
	input  st_pkg::bus_addr_t bus_addr_i,
	st_cfg_if.decode          cfg,
	output logic              ram_en_o
);

	logic size_hit;   // below the configured ram top
	logic viking_st;  // $c00000 window
	logic viking_hi;  // $e80000 window
	logic viking_hit;

	always_comb begin
		case (cfg.mem_size)
			st_pkg::MEM_512K: size_hit = (bus_addr_i[23:19] == 5'b00000);
			st_pkg::MEM_1M:   size_hit = (bus_addr_i[23:20] == 4'b0000);
			st_pkg::MEM_2M:   size_hit = (bus_addr_i[23:21] == 3'b000);
			st_pkg::MEM_4M:   size_hit = (bus_addr_i[23:22] == 2'b00);
			st_pkg::MEM_8M:   size_hit = ~bus_addr_i[23];
			// 14M ends at $e00000, rom and io live above
			st_pkg::MEM_14M:  size_hit = (bus_addr_i[23:21] != 3'b111);
			default:          size_hit = 1'b0; // undefined sizes
		endcase
	end

	assign viking_st = (bus_addr_i[23:18] == st_pkg::VIKING_BASE_ST);
	assign viking_hi = (bus_addr_i[23:19] == st_pkg::VIKING_BASE_HI);

	// window location follows the mode
	assign viking_hit = cfg.viking_enable &
		(cfg.steroids ? viking_hi : viking_st);

	assign ram_en_o = size_hit | viking_hit; // no clock in this path

endmodule

// File: hw/st_viking_detect.sv
module st_viking_detect #(
	parameter int VIKING_HITS = 255 // 1..255
) (
	input  logic              clk_32,
	input  logic              xsint,
	input  st_pkg::bus_addr_t bus_addr_i,
	input  logic              bus_as_n_i,
	input  logic              bus_en_i,   // 8 MHz bus enable
	st_cfg_if.detect          cfg
);

	localparam logic [7:0] HITS_MAX = 8'(VIKING_HITS);

	logic in_win;  // address inside the window for this mode
	logic hit;

	assign in_win = cfg.steroids ?
		(bus_addr_i[23:19] == st_pkg::VIKING_BASE_HI) :
		(bus_addr_i[23:18] == st_pkg::VIKING_BASE_ST);

	// one count per bus cycle with the strobe down
	assign hit = bus_en_i & ~bus_as_n_i & cfg.viking_enable & in_win;

	// a driver hammers the window, a stray probe only touches it
	// so video switches over only after many accesses
	always_ff @(posedge clk_32 or negedge xsint) begin
		if (!xsint) begin
			cfg.viking_hits   <= 8'd0;
			cfg.viking_active <= 1'b0;
		end else begin
			if (hit && cfg.viking_hits != HITS_MAX)
				cfg.viking_hits <= cfg.viking_hits + 8'd1; // saturates
			if (cfg.viking_hits == HITS_MAX)
				cfg.viking_active <= 1'b1; // sticky until reset
		end
	end

endmodule

// File: hw/st_audio_mix.sv
module st_audio_mix (
	input  logic                     clk_32,
	input  logic                     xsint,
	input  logic [st_pkg::YM_W-1:0]  ym_l_i,
	input  logic [st_pkg::YM_W-1:0]  ym_r_i,
	input  logic [st_pkg::DMA_W-1:0] dma_l_i,
	input  logic [st_pkg::DMA_W-1:0] dma_r_i,
	output logic                     audio_l_o, // sigma-delta bitstream
	output logic                     audio_r_o
);

	localparam int YM_PAD  = st_pkg::MIX_W - 1 - st_pkg::YM_W;  // low fill bits
	localparam int DMA_PAD = st_pkg::MIX_W - 1 - st_pkg::DMA_W;
	localparam logic [st_pkg::YM_W-1:0]  YM_MID  = 1 << (st_pkg::YM_W - 1);
	localparam logic [st_pkg::DMA_W-1:0] DMA_MID = 1 << (st_pkg::DMA_W - 1);

	logic [st_pkg::YM_W-1:0]  ym_in  [2]; // 0 left, 1 right
	logic [st_pkg::DMA_W-1:0] dma_in [2];
	logic [1:0]               dac_bit;

	assign ym_in[0]  = ym_l_i;
	assign ym_in[1]  = ym_r_i;
	assign dma_in[0] = dma_l_i;
	assign dma_in[1] = dma_r_i;

	for (genvar ch = 0; ch < 2; ch++) begin : g_ch
		logic [st_pkg::YM_W-1:0]  ym_s;   // offset removed, two's complement
		logic [st_pkg::DMA_W-1:0] dma_s;
		logic [st_pkg::MIX_W-1:0] ym_wide;
		logic [st_pkg::MIX_W-1:0] dma_wide;
		logic [st_pkg::MIX_W-1:0] mix_q;
		logic [st_pkg::MIX_W-1:0] u;      // mix as unsigned code
		logic [st_pkg::MIX_W-1:0] acc_q;
		logic [st_pkg::MIX_W:0]   acc_sum;
		logic                     dac_q;

		assign ym_s  = ym_in[ch] - YM_MID;
		assign dma_s = dma_in[ch] - DMA_MID;

		// sign extend one bit, repeat the msbs into the low end
		assign ym_wide  = {ym_s[st_pkg::YM_W-1], ym_s, ym_s[st_pkg::YM_W-1 -: YM_PAD]};
		assign dma_wide = {dma_s[st_pkg::DMA_W-1], dma_s, dma_s[st_pkg::DMA_W-1 -: DMA_PAD]};

		assign u       = {~mix_q[st_pkg::MIX_W-1], mix_q[st_pkg::MIX_W-2:0]};
		assign acc_sum = {1'b0, acc_q} + {1'b0, u};

		// first order modulator, carry out is the density
		always_ff @(posedge clk_32 or negedge xsint) begin
			if (!xsint) begin
				mix_q <= '0;
				acc_q <= '0;
				dac_q <= 1'b0;
			end else begin
				mix_q <= ym_wide + dma_wide; // wraps mod 2^15
				acc_q <= acc_sum[st_pkg::MIX_W-1:0];
				dac_q <= acc_sum[st_pkg::MIX_W];
			end
		end

		assign dac_bit[ch] = dac_q;
	end

	assign audio_l_o = dac_bit[0];
	assign audio_r_o = dac_bit[1];

endmodule

// File: hw/st_core.sv
module st_core #(
	parameter int VIKING_HITS = 255 // accesses before video switches
) (
	input  logic                     clk_32,
	input  logic                     xsint,
	// axi4-lite config port
	input  logic [7:0]               s_axil_awaddr_i,
	input  logic                     s_axil_awvalid_i,
	output logic                     s_axil_awready_o,
	input  logic [31:0]              s_axil_wdata_i,
	input  logic [3:0]               s_axil_wstrb_i,
	input  logic                     s_axil_wvalid_i,
	output logic                     s_axil_wready_o,
	output logic [1:0]               s_axil_bresp_o,
	output logic                     s_axil_bvalid_o,
	input  logic                     s_axil_bready_i,
	input  logic [7:0]               s_axil_araddr_i,
	input  logic                     s_axil_arvalid_i,
	output logic                     s_axil_arready_o,
	output logic [31:0]              s_axil_rdata_o,
	output logic [1:0]               s_axil_rresp_o,
	output logic                     s_axil_rvalid_o,
	input  logic                     s_axil_rready_i,
	// 68000 side
	input  st_pkg::bus_addr_t        bus_addr_i,
	input  logic                     bus_as_n_i,
	input  logic                     bus_en_i,
	// sound sources
	input  logic [st_pkg::YM_W-1:0]  ym_l_i,
	input  logic [st_pkg::YM_W-1:0]  ym_r_i,
	input  logic [st_pkg::DMA_W-1:0] dma_l_i,
	input  logic [st_pkg::DMA_W-1:0] dma_r_i,
	output logic                     ram_en_o,
	output logic                     viking_active_o,
	output logic                     audio_l_o,
	output logic                     audio_r_o
);

	st_cfg_if cfg ();

	st_cfg_regs regs_inst (.*, .cfg(cfg));

	st_ram_decode decode_inst (
		.bus_addr_i (bus_addr_i),
		.cfg        (cfg),
		.ram_en_o   (ram_en_o)
	);

	st_viking_detect #(.VIKING_HITS(VIKING_HITS)) detect_inst (
		.clk_32     (clk_32),
		.xsint      (xsint),
		.bus_addr_i (bus_addr_i),
		.bus_as_n_i (bus_as_n_i),
		.bus_en_i   (bus_en_i),
		.cfg        (cfg)
	);

	st_audio_mix audio_inst (.*);

	assign viking_active_o = cfg.viking_active; // video source select

endmodule

// File: test/st_core_chk.sv
module st_core_chk (
	input logic              clk_32,
	input logic              xsint,
	input logic              bvalid_i,
	input logic              bready_i,
	input logic              rvalid_i,
	input logic              rready_i,
	input logic [31:0]       rdata_i,
	input logic              viking_active_i,
	input logic              viking_enable_i,
	input st_pkg::mem_size_e mem_size_i,
	input st_pkg::bus_addr_t bus_addr_i,
	input logic              ram_en_i
);

	logic st_win; // $c00000..$c3ffff

	assign st_win = ({bus_addr_i, 1'b0} >= 24'hc00000) && ({bus_addr_i, 1'b0} <= 24'hc3ffff);

	a_bvalid_hold: assert property (@(posedge clk_32) disable iff (!xsint)
		bvalid_i && !bready_i |=> bvalid_i)
		else $error("bvalid dropped before bready");

	a_rvalid_hold: assert property (@(posedge clk_32) disable iff (!xsint)
		rvalid_i && !rready_i |=> rvalid_i && $stable(rdata_i))
		else $error("read response changed before rready");

	// sticky until reset
	a_active_sticky: assert property (@(posedge clk_32) disable iff (!xsint)
		viking_active_i |=> viking_active_i)
		else $error("viking_active fell without reset");

	// 14M covers $c00000 as plain ram
	a_window_off: assert property (@(posedge clk_32) disable iff (!xsint)
		!viking_enable_i && st_win && mem_size_i != st_pkg::MEM_14M |-> !ram_en_i)
		else $error("ram enabled in unmapped viking window");

endmodule

bind st_core st_core_chk chk_inst (
	.clk_32          (clk_32),
	.xsint           (xsint),
	.bvalid_i        (s_axil_bvalid_o),
	.bready_i        (s_axil_bready_i),
	.rvalid_i        (s_axil_rvalid_o),
	.rready_i        (s_axil_rready_i),
	.rdata_i         (s_axil_rdata_o),
	.viking_active_i (viking_active_o),
	.viking_enable_i (cfg.viking_enable),
	.mem_size_i      (cfg.mem_size),
	.bus_addr_i      (bus_addr_i),
	.ram_en_i        (ram_en_o)
);

// File: test/st_core_tb.sv
module st_core_tb;

	localparam int HITS       = 20; // detector threshold for this build
	localparam int AUDIO_SETS = 3;
	localparam int WAIT_MAX   = 16; // cycles per axi handshake
	// audio windows dominate, the other tests fit in the margin
	localparam int RUN_CYCLES = AUDIO_SETS * (32768 + 8) + 4000;

	logic        clk_32 = 1'b0;
	logic        xsint = 1'b0;
	logic        s_axil_awvalid_i = 1'b0, s_axil_wvalid_i = 1'b0, s_axil_bready_i = 1'b0;
	logic        s_axil_arvalid_i = 1'b0, s_axil_rready_i = 1'b0;
	logic [7:0]  s_axil_awaddr_i = '0, s_axil_araddr_i = '0;
	logic [31:0] s_axil_wdata_i = '0;
	logic [3:0]  s_axil_wstrb_i = 4'hf;
	logic        s_axil_awready_o, s_axil_wready_o, s_axil_bvalid_o;
	logic        s_axil_arready_o, s_axil_rvalid_o;
	logic [1:0]  s_axil_bresp_o, s_axil_rresp_o;
	logic [31:0] s_axil_rdata_o;
	st_pkg::bus_addr_t bus_addr_i = '0;
	logic        bus_as_n_i = 1'b1; // strobe idle
	logic        bus_en_i = 1'b0;
	logic [st_pkg::YM_W-1:0]  ym_l_i = '0, ym_r_i = '0;
	logic [st_pkg::DMA_W-1:0] dma_l_i = '0, dma_r_i = '0;
	logic        ram_en_o, viking_active_o, audio_l_o, audio_r_o;
	logic [31:0] lcg_state = 32'h92e5;
	int          mismatches = 0;
	int          timeouts = 0;

	st_core #(.VIKING_HITS(HITS)) st_core_inst (.*);

	always #50 clk_32 = ~clk_32;

	initial begin : watchdog
		#(RUN_CYCLES * 100);
		$display("watchdog expired, tests ran past %0d cycles", RUN_CYCLES);
		$display("Test FAILED");
		$finish;
	end

	function automatic logic [31:0] next_rand();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
		if (exp !== act) begin
			$display("mismatch %s: expected %h, actual %h", name, exp, act);
			mismatches++;
		end
	endtask

	// valids stay up until bvalid shows
	// response then left pending one cycle before bready
	task automatic axi_write(input logic [7:0] addr, input logic [31:0] data,
		output logic [1:0] resp);
		int n;
		int aw_cnt;
		int w_cnt;
		@(negedge clk_32);
		s_axil_awaddr_i  = addr;
		s_axil_wdata_i   = data;
		s_axil_awvalid_i = 1'b1;
		s_axil_wvalid_i  = 1'b1;
		n = 0;
		aw_cnt = 0;
		w_cnt = 0;
		do begin
			@(posedge clk_32); // readies as the edge sees them
			aw_cnt += s_axil_awready_o;
			w_cnt  += s_axil_wready_o;
			@(negedge clk_32);
			n++;
		end while (!s_axil_bvalid_o && n < WAIT_MAX);
		s_axil_awvalid_i = 1'b0;
		s_axil_wvalid_i  = 1'b0;
		resp = s_axil_bresp_o;
		if (!s_axil_bvalid_o) begin
			$display("write to offset %h got no response", addr);
			timeouts++;
		end
		check($sformatf("axi write %h awready", addr), 32'd1, aw_cnt);
		check($sformatf("axi write %h wready", addr), 32'd1, w_cnt);
		@(negedge clk_32); // bvalid must hold here
		s_axil_bready_i = 1'b1;
		@(negedge clk_32);
		s_axil_bready_i = 1'b0;
	endtask

	task automatic axi_read(input logic [7:0] addr, output logic [31:0] data,
		output logic [1:0] resp);
		int n;
		int ar_cnt;
		@(negedge clk_32);
		s_axil_araddr_i  = addr;
		s_axil_arvalid_i = 1'b1;
		n = 0;
		ar_cnt = 0;
		do begin
			@(posedge clk_32);
			ar_cnt += s_axil_arready_o;
			@(negedge clk_32);
			n++;
		end while (!s_axil_rvalid_o && n < WAIT_MAX);
		s_axil_arvalid_i = 1'b0;
		data = s_axil_rdata_o;
		resp = s_axil_rresp_o;
		if (!s_axil_rvalid_o) begin
			$display("read of offset %h got no response", addr);
			timeouts++;
		end
		check($sformatf("axi read %h arready", addr), 32'd1, ar_cnt);
		@(negedge clk_32); // rvalid and rdata must hold here
		s_axil_rready_i = 1'b1;
		@(negedge clk_32);
		s_axil_rready_i = 1'b0;
	endtask

	// one bus clock with the given address and strobes
	task automatic bus_cycle(input logic [23:0] byte_addr, input logic as_n, input logic en);
		@(negedge clk_32);
		bus_addr_i = byte_addr[23:1];
		bus_as_n_i = as_n;
		bus_en_i   = en;
	endtask

	function automatic logic [24:0] size_top(input int size);
		case (size)
			0: return 25'h0080000;
			1: return 25'h0100000;
			2: return 25'h0200000;
			3: return 25'h0400000;
			4: return 25'h0800000;
			5: return 25'h0e00000; // rom and io above
			default: return '0;    // no ram
		endcase
	endfunction

	// ram enable from byte address ranges
	function automatic logic ram_expect(input int size, input logic [23:0] a,
		input logic ste_mode, input logic vk_en);
		logic win;
		win = ste_mode ? (a >= 24'he80000 && a <= 24'hefffff) :
			(a >= 24'hc00000 && a <= 24'hc3ffff);
		return ({1'b0, a} < size_top(size)) || (vk_en && win);
	endfunction

	// offset removal, widening and sign flip per channel
	function automatic logic [14:0] mix_code(input logic [9:0] ym, input logic [7:0] dma);
		logic [9:0]  ys;
		logic [7:0]  ds;
		logic [14:0] sum;
		ys  = ym - 10'h200;
		ds  = dma - 8'h80;
		sum = {ys[9], ys, ys[9:6]} + {ds[7], ds, ds[7:2]};
		return {~sum[14], sum[13:0]};
	endfunction

	task automatic test_regs();
		logic [31:0] word;
		logic [31:0] data;
		logic [1:0]  resp;
		word = next_rand();
		axi_read(st_pkg::CTRL_OFFSET, data, resp);
		check("regs reset value", 32'd0, data);
		check("regs reset rresp", 32'd0, resp);
		axi_write(st_pkg::CTRL_OFFSET, word, resp);
		check("regs ctrl bresp", 32'd0, resp);
		axi_read(st_pkg::CTRL_OFFSET, data, resp);
		check("regs readback", word, data);
		axi_write(8'h08, ~word, resp); // unmapped
		check("regs bad write bresp", 32'd2, resp);
		axi_read(st_pkg::CTRL_OFFSET, data, resp);
		check("regs after bad write", word, data);
		axi_read(8'h08, data, resp);
		check("regs bad read data", 32'd0, data);
		check("regs bad read rresp", 32'd2, resp);
	endtask

	task automatic test_ram_size();
		logic [1:0]  resp;
		logic [31:0] r;
		logic [23:0] a;
		for (int size = 0; size < 8; size++) begin
			axi_write(st_pkg::CTRL_OFFSET, 32'(size) << st_pkg::CTRL_MEM_LSB, resp);
			for (int i = 0; i < 10; i++) begin
				r = next_rand();
				a = {r[23:1], 1'b0};
				if (size < 6 && i == 0)
					a = 24'(size_top(size) - 25'd2); // last word inside
				else if (size < 6 && i == 1)
					a = 24'(size_top(size)); // first word outside
				else if (i == 2)
					a = 24'hc00000; // viking window, not mapped
				bus_cycle(a, 1'b1, 1'b0);
				@(posedge clk_32);
				check($sformatf("ram size %0d addr %h", size, a),
					ram_expect(size, a, 1'b0, 1'b0), ram_en_o);
			end
		end
	endtask

	task automatic test_viking_enable();
		logic [1:0]  resp;
		logic [31:0] data;
		// viking bit with 14M, window must stay off
		axi_write(st_pkg::CTRL_OFFSET, (32'd1 << st_pkg::CTRL_VIKING_BIT) |
			(32'd5 << st_pkg::CTRL_MEM_LSB), resp);
		repeat (4) bus_cycle(24'hc00000, 1'b0, 1'b1); // would count if mapped
		bus_cycle(24'h000000, 1'b1, 1'b0);
		axi_read(st_pkg::STATUS_OFFSET, data, resp);
		check("viking off at 14M, hits", 32'd0, data);
		// steroids at 512K moves the window up
		axi_write(st_pkg::CTRL_OFFSET, (32'd1 << st_pkg::CTRL_STE_BIT) |
			(32'd1 << st_pkg::CTRL_MSTE_BIT), resp);
		bus_cycle(24'he80000, 1'b1, 1'b0);
		@(posedge clk_32);
		check("steroids window e80000", ram_expect(0, 24'he80000, 1'b1, 1'b1), ram_en_o);
		bus_cycle(24'hc00000, 1'b1, 1'b0);
		@(posedge clk_32);
		check("steroids window c00000", ram_expect(0, 24'hc00000, 1'b1, 1'b1), ram_en_o);
	endtask

	task automatic test_viking_detect();
		logic [1:0]  resp;
		logic [31:0] data;
		axi_write(st_pkg::CTRL_OFFSET, (32'd1 << st_pkg::CTRL_VIKING_BIT) |
			(32'd4 << st_pkg::CTRL_MEM_LSB), resp); // 8M, plain window
		for (int i = 0; i < HITS - 1; i++) begin
			bus_cycle(24'hc00000 + 24'(i * 2), 1'b0, 1'b1); // counts
			bus_cycle(24'hc00000, 1'b0, 1'b0);              // enable low
			bus_cycle(24'h100000, 1'b0, 1'b1);              // outside window
		end
		bus_cycle(24'h000000, 1'b1, 1'b0);
		repeat (2) @(negedge clk_32);
		check("detect below threshold", 32'd0, viking_active_o);
		axi_read(st_pkg::STATUS_OFFSET, data, resp);
		check("detect status below threshold", 32'(HITS - 1), data);
		bus_cycle(24'hc3fffe, 1'b0, 1'b1); // last hit, top of window
		bus_cycle(24'h000000, 1'b1, 1'b0);
		@(negedge clk_32); // second cycle after the hit
		check("detect active after last hit", 32'd1, viking_active_o);
		repeat (3) bus_cycle(24'hc00000, 1'b0, 1'b1); // saturates
		bus_cycle(24'h000000, 1'b1, 1'b0);
		axi_read(st_pkg::STATUS_OFFSET, data, resp);
		check("detect status saturated", 32'h100 | 32'(HITS), data);
	endtask

	task automatic test_audio();
		logic [31:0] r1;
		logic [31:0] r2;
		int          ones_l;
		int          ones_r;
		for (int set = 0; set < AUDIO_SETS; set++) begin
			r1 = next_rand();
			r2 = next_rand();
			@(negedge clk_32);
			ym_l_i  = r1[31:22];
			ym_r_i  = r1[21:12];
			dma_l_i = r2[31:24];
			dma_r_i = r2[23:16];
			repeat (4) @(negedge clk_32); // sum and carry settle
			ones_l = 0;
			ones_r = 0;
			repeat (32768) begin
				@(negedge clk_32);
				ones_l += audio_l_o;
				ones_r += audio_r_o;
			end
			check($sformatf("audio left set %0d", set), mix_code(ym_l_i, dma_l_i), ones_l);
			check($sformatf("audio right set %0d", set), mix_code(ym_r_i, dma_r_i), ones_r);
		end
	endtask

	initial begin
		repeat (10) @(negedge clk_32);
		xsint = 1'b1;
		test_regs();
		test_ram_size();
		test_viking_enable();
		test_viking_detect();
		test_audio();
		$display("errors: %0d mismatches, %0d handshake timeouts", mismatches, timeouts);
		if (mismatches == 0 && timeouts == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

endmodule

// File: st_core.f
hw/st_pkg.sv
hw/st_cfg_if.sv
hw/st_cfg_regs.sv
hw/st_ram_decode.sv
hw/st_viking_detect.sv
hw/st_audio_mix.sv
hw/st_core.sv
test/st_core_chk.sv
test/st_core_tb.sv

// File: run.sh
#!/bin/sh
# build the testbench with verilator, run it, then scan the log
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --top-module st_core_tb \
	-f st_core.f -o st_core_sim
status=0
./obj_dir/st_core_sim > sim.log 2>&1 || status=$?
cat sim.log
if [ "$status" -ne 0 ] || grep -q "Test FAILED" sim.log; then
	echo "simulation failed"
	exit 1
fi
echo "simulation passed"
